// File: hw/st_bus_pkg.sv
`default_nettype none

package st_bus_pkg;

	// cpu register addresses, word index on the bus
	typedef enum logic [2:0] {
		ctrl_data = 3'd2,
		mode      = 3'd3,
		base_hi   = 3'd4,
		base_mid  = 3'd5,
		base_lo   = 3'd6
	} reg_addr_e;

	// dma mode register, written as a full word
	typedef struct packed {
		logic [10:0] unused_hi;
		// ctrl_data hits the sector counter
		logic        scnt_sel;
		// ctrl_data hits the acsi port instead of the fdc
		logic        acsi_sel;
		// fdc register index, bit 0 also marks acsi follow-up bytes
		logic [1:0]  fdc_reg;
		logic        unused_lo;
	} mode_reg_t;

	// single cycle strobes toward the disk controllers
	typedef struct packed {
		logic       fdc_wr;
		logic [1:0] fdc_reg;
		logic       acsi_first;
		logic       acsi_next;
		logic       fdc_status_rd;
		logic       acsi_status_rd;
		logic [7:0] wdata;
	} ctrl_strobe_t;

endpackage

`default_nettype wire

// File: hw/disk_ctrl_pkg.sv
`default_nettype none

package disk_ctrl_pkg;

	// fdc command classes, upper nibble of the command byte
	localparam logic [3:0] FDC_RESTORE   = 4'b0000;
	localparam logic [3:0] FDC_SEEK      = 4'b0001;
	localparam logic [3:0] FDC_FORCE_INT = 4'b1101;
	// step and sector commands, bit 0 of the class is a flag
	localparam logic [2:0] FDC_STEP      = 3'b001;
	localparam logic [2:0] FDC_STEP_IN   = 3'b010;
	localparam logic [2:0] FDC_STEP_OUT  = 3'b011;
	localparam logic [2:0] FDC_RD_SECT   = 3'b100;
	localparam logic [2:0] FDC_WR_SECT   = 3'b101;

	typedef struct packed {
		logic [3:0] cls;
		logic [3:0] flags;
	} fdc_cmd_t;

	typedef struct packed {
		logic [2:0] target;
		logic [4:0] opcode;
	} acsi_first_t;

	// one data byte, meaning depends on the mode register
	typedef union packed {
		fdc_cmd_t    fdc;
		acsi_first_t acsi;
	} cmd_byte_u;

	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] data;
		logic [7:0] status;
		logic       busy;
	} fdc_regs_t;

	typedef struct packed {
		logic [2:0]      target;
		logic [4:0]      opcode;
		logic            busy;
		logic [4:0][7:0] parms;
	} acsi_stat_t;

endpackage

`default_nettype wire

// File: hw/dma_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regfile
	import st_bus_pkg::*;
	import disk_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         sel,
	input  logic         rw,
	input  logic         lds,
	input  reg_addr_e    addr,
	input  logic [15:0]  din,
	input  fdc_regs_t    fdc,
	input  logic         acsi_busy,
	input  logic         ack_pulse,
	output ctrl_strobe_t strobe,
	output logic [23:0]  base,
	output logic [7:0]   scnt,
	output logic [15:0]  dout
);

	mode_reg_t mode_r;
	logic      wr;
	logic      rd;
	logic      ctrl_wr;
	logic      ctrl_rd;

	assign wr = sel && !rw;
	assign rd = sel && rw;
	// controller access, sector counter not selected
	assign ctrl_wr = wr && !lds && (addr == ctrl_data) && !mode_r.scnt_sel;
	assign ctrl_rd = rd && (addr == ctrl_data) && !mode_r.scnt_sel;

	assign strobe.fdc_wr         = ctrl_wr && !mode_r.acsi_sel;
	assign strobe.fdc_reg        = mode_r.fdc_reg;
	// acsi first byte when a1 is low
	assign strobe.acsi_first     = ctrl_wr && mode_r.acsi_sel && !mode_r.fdc_reg[0];
	assign strobe.acsi_next      = ctrl_wr && mode_r.acsi_sel && mode_r.fdc_reg[0];
	assign strobe.fdc_status_rd  = ctrl_rd && !mode_r.acsi_sel && (mode_r.fdc_reg == 2'd0);
	assign strobe.acsi_status_rd = ctrl_rd && mode_r.acsi_sel;
	assign strobe.wdata          = din[7:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_r <= '0;
			base   <= '0;
			scnt   <= '0;
		end else begin
			// transfer done, all sectors gone
			if (ack_pulse)
				scnt <= '0;
			// cpu write wins over the ack clear
			if (wr && !lds && (addr == ctrl_data) && mode_r.scnt_sel)
				scnt <= din[7:0];
			// mode takes any byte lane
			if (wr && (addr == mode))
				mode_r <= din;
			if (wr && !lds && (addr == base_hi))
				base[23:16] <= din[7:0];
			if (wr && !lds && (addr == base_mid))
				base[15:8] <= din[7:0];
			if (wr && !lds && (addr == base_lo))
				base[7:0] <= din[7:0];
		end
	end

	always_comb begin
		dout = '0;
		if (rd) begin
			case (addr)
				ctrl_data: begin
					if (mode_r.scnt_sel)
						dout = {8'h00, scnt};
					else if (mode_r.acsi_sel)
						// bit 3 reports the target as busy
						dout = {8'h00, 4'h0, acsi_busy, 3'h0};
					else begin
						case (mode_r.fdc_reg)
							2'd0:    dout = {8'h00, fdc.status};
							2'd1:    dout = {8'h00, fdc.track};
							2'd2:    dout = {8'h00, fdc.sector};
							default: dout = {8'h00, fdc.data};
						endcase
					end
				end
				// dma status, bit 0 always ok
				mode:     dout = {14'd0, scnt != 8'd0, 1'b1};
				base_hi:  dout = {8'h00, base[23:16]};
				base_mid: dout = {8'h00, base[15:8]};
				base_lo:  dout = {8'h00, base[7:0]};
				default:  dout = '0;
			endcase
		end
	end

	// the controllers must never see two writes at once
	a_one_ctrl_wr: assert property (@(posedge clk) disable iff (reset)
		$onehot0({strobe.fdc_wr, strobe.acsi_first, strobe.acsi_next}));

endmodule

`default_nettype wire

// File: hw/fdc_emul.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_emul
	import st_bus_pkg::*;
	import disk_ctrl_pkg::*;
#(
	parameter int unsigned MOTOR_CYCLES = 65535
) (
	input  logic         clk,
	input  logic         reset,
	input  ctrl_strobe_t strobe,
	input  logic         wr_prot,
	input  logic         ack_pulse,
	output fdc_regs_t    regs,
	output logic         xfer_req,
	output logic         irq
);

	localparam int MW = $clog2(MOTOR_CYCLES + 1);

	cmd_byte_u     cmd_in;
	logic          cmd_wr;
	logic [7:0]    cmd_q;
	logic [7:0]    track_q;
	logic [7:0]    sector_q;
	logic [7:0]    data_q;
	// 3 waits for io controller, 2 and 1 count down
	logic [1:0]    busy;
	logic          step_dir;
	logic [MW-1:0] motor_cnt;

	assign cmd_in = strobe.wdata;
	assign cmd_wr = strobe.fdc_wr && (strobe.fdc_reg == 2'd0);

	// sector commands hand over to the io controller
	assign xfer_req = cmd_wr && ((cmd_in.fdc.cls[3:1] == FDC_RD_SECT) ||
		((cmd_in.fdc.cls[3:1] == FDC_WR_SECT) && !wr_prot));

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_q     <= '0;
			track_q   <= '0;
			sector_q  <= '0;
			data_q    <= '0;
			busy      <= '0;
			step_dir  <= 1'b0;
			motor_cnt <= '0;
			irq       <= 1'b0;
		end else begin
			if (motor_cnt != '0)
				motor_cnt <= motor_cnt - 1'b1;
			// stall at 3 until the io controller acks
			if (busy == 2'd3) begin
				if (ack_pulse)
					busy <= 2'd1;
			end else if (busy != 2'd0)
				busy <= busy - 2'd1;
			// end of busy phase
			if (busy == 2'd1)
				irq <= 1'b1;
			if (strobe.fdc_status_rd)
				irq <= 1'b0;
			if (cmd_wr) begin
				cmd_q <= strobe.wdata;
				busy  <= 2'd2;
				// type i and ii spin up the motor
				if (!cmd_in.fdc.cls[3] || (cmd_in.fdc.cls[3:2] == 2'b10))
					motor_cnt <= MW'(MOTOR_CYCLES);
				if (cmd_in.fdc.cls == FDC_RESTORE)
					track_q <= '0;
				if (cmd_in.fdc.cls == FDC_SEEK)
					track_q <= data_q;
				// step keeps the last direction, bit 0 is the update flag
				if ((cmd_in.fdc.cls[3:1] == FDC_STEP) && cmd_in.fdc.cls[0])
					track_q <= step_dir ? track_q + 8'd1 : track_q - 8'd1;
				if (cmd_in.fdc.cls[3:1] == FDC_STEP_IN) begin
					step_dir <= 1'b1;
					if (cmd_in.fdc.cls[0])
						track_q <= track_q + 8'd1;
				end
				if (cmd_in.fdc.cls[3:1] == FDC_STEP_OUT) begin
					step_dir <= 1'b0;
					if (cmd_in.fdc.cls[0])
						track_q <= track_q - 8'd1;
				end
				if (xfer_req)
					busy <= 2'd3;
				// force interrupt ends busy at once
				if (cmd_in.fdc.cls == FDC_FORCE_INT)
					busy <= 2'd1;
			end
			if (strobe.fdc_wr && (strobe.fdc_reg == 2'd1))
				track_q <= strobe.wdata;
			if (strobe.fdc_wr && (strobe.fdc_reg == 2'd2))
				sector_q <= strobe.wdata;
			if (strobe.fdc_wr && (strobe.fdc_reg == 2'd3))
				data_q <= strobe.wdata;
		end
	end

	assign regs.cmd    = cmd_q;
	assign regs.track  = track_q;
	assign regs.sector = sector_q;
	assign regs.data   = data_q;
	assign regs.busy   = busy != 2'd0;
	// track 0 flag only meaningful after type i
	assign regs.status = {motor_cnt != '0, wr_prot, 3'b000,
		!cmd_q[7] && (track_q == 8'd0), 1'b0, busy != 2'd0};

	// only the io controller or a new command releases a waiting transfer
	a_busy_hold: assert property (@(posedge clk) disable iff (reset)
		(busy == 2'd3) && !ack_pulse && !cmd_wr |=> (busy == 2'd3));

endmodule

`default_nettype wire

// File: hw/acsi_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module acsi_cmd
	import st_bus_pkg::*;
	import disk_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  ctrl_strobe_t strobe,
	input  logic [7:0]   enable,
	input  logic         ack_pulse,
	output acsi_stat_t   stat,
	output logic         xfer_req,
	output logic         irq
);

	cmd_byte_u       first_byte;
	logic [2:0]      target;
	logic [4:0]      opcode;
	logic [2:0]      byte_cnt;
	logic [4:0][7:0] parms;
	logic            busy;
	logic            tgt_on;

	assign first_byte = strobe.wdata;
	assign tgt_on = enable[target];
	// last parameter byte to a live target starts the transfer
	assign xfer_req = strobe.acsi_next && tgt_on && (byte_cnt == 3'd4);

	always_ff @(posedge clk) begin
		if (reset) begin
			target   <= '0;
			opcode   <= '0;
			byte_cnt <= '0;
			busy     <= 1'b0;
			irq      <= 1'b0;
		end else begin
			if (ack_pulse && busy) begin
				irq  <= 1'b1;
				busy <= 1'b0;
			end
			if (strobe.acsi_status_rd)
				irq <= 1'b0;
			if (strobe.acsi_first) begin
				target   <= first_byte.acsi.target;
				opcode   <= first_byte.acsi.opcode;
				byte_cnt <= '0;
				// silent targets never answer
				if (enable[first_byte.acsi.target])
					irq <= 1'b1;
			end
			if (strobe.acsi_next && (byte_cnt < 3'd5)) begin
				byte_cnt <= byte_cnt + 3'd1;
				// auto ack for the first four
				if (tgt_on && (byte_cnt < 3'd4))
					irq <= 1'b1;
				if (xfer_req)
					busy <= 1'b1;
			end
		end
	end

	// parameter bytes in arrival order
	always_ff @(posedge clk) begin
		if (strobe.acsi_next && (byte_cnt < 3'd5))
			parms[byte_cnt] <= strobe.wdata;
	end

	assign stat.target = target;
	assign stat.opcode = opcode;
	assign stat.busy   = busy;
	assign stat.parms  = parms;

	a_byte_cnt: assert property (@(posedge clk) disable iff (reset) byte_cnt <= 3'd5);

endmodule

`default_nettype wire

// File: hw/dio_link.sv
`timescale 1ns/1ps
`default_nettype none

module dio_link
	import disk_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        ack,
	input  logic        nak,
	input  logic        fdc_req,
	input  logic        acsi_req,
	input  logic [4:0]  dio_idx,
	input  fdc_regs_t   fdc,
	input  acsi_stat_t  acsi,
	input  logic [23:0] base,
	input  logic [7:0]  scnt,
	input  logic [1:0]  drv_sel,
	input  logic        drv_side,
	output logic        ack_pulse,
	output logic        br,
	output logic [7:0]  dio_data
);

	// two sync stages plus one for edge detect
	logic [2:0] ack_sync;
	logic [2:0] nak_sync;
	logic       nak_pulse;

	assign ack_pulse = ack_sync[1] && !ack_sync[2];
	assign nak_pulse = nak_sync[1] && !nak_sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_sync <= '0;
			nak_sync <= '0;
			br       <= 1'b0;
		end else begin
			ack_sync <= {ack_sync[1:0], ack};
			nak_sync <= {nak_sync[1:0], nak};
			// a fresh request beats a release
			if (fdc_req || acsi_req)
				br <= 1'b1;
			else if (ack_pulse || nak_pulse)
				br <= 1'b0;
		end
	end

	// status snapshot for the io controller
	always_comb begin
		case (dio_idx)
			5'd0:    dio_data = base[23:16];
			5'd1:    dio_data = base[15:8];
			5'd2:    dio_data = base[7:0];
			5'd3:    dio_data = scnt;
			5'd4:    dio_data = fdc.cmd;
			5'd5:    dio_data = fdc.track;
			5'd6:    dio_data = fdc.sector;
			5'd7:    dio_data = fdc.data;
			5'd8:    dio_data = {3'b000, acsi.busy, drv_sel, drv_side, fdc.busy};
			5'd9:    dio_data = {acsi.target, acsi.opcode};
			5'd10:   dio_data = acsi.parms[0];
			5'd11:   dio_data = acsi.parms[1];
			5'd12:   dio_data = acsi.parms[2];
			5'd13:   dio_data = acsi.parms[3];
			5'd14:   dio_data = acsi.parms[4];
			default: dio_data = 8'h00;
		endcase
	end

	a_br_req: assert property (@(posedge clk) disable iff (reset)
		$rose(br) |-> $past(fdc_req || acsi_req));

endmodule

`default_nettype wire

// File: hw/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top
	import st_bus_pkg::*;
	import disk_ctrl_pkg::*;
#(
	parameter int unsigned MOTOR_CYCLES = 65535
) (
	input  logic        clk,
	input  logic        reset,
	// cpu register port
	input  logic        sel,
	input  logic        rw,
	input  logic        lds,
	input  reg_addr_e   addr,
	input  logic [15:0] din,
	output logic [15:0] dout,
	// to the mfp and bus arbiter
	output logic        irq,
	output logic        br,
	// system config
	input  logic        fdc_wr_prot,
	input  logic [7:0]  acsi_enable,
	// io controller link
	input  logic [4:0]  dio_idx,
	output logic [7:0]  dio_data,
	input  logic        dio_ack,
	input  logic        dio_nak,
	// drive select from the psg
	input  logic        drv_side,
	input  logic [1:0]  drv_sel
);

	ctrl_strobe_t strobe;
	fdc_regs_t    fdc;
	acsi_stat_t   acsi;
	logic [23:0]  base;
	logic [7:0]   scnt;
	logic         ack_pulse;
	logic         fdc_req;
	logic         acsi_req;
	logic         fdc_irq;
	logic         acsi_irq;

	// one interrupt line shared by both controllers
	assign irq = fdc_irq || acsi_irq;

	dma_regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.sel       (sel),
		.rw        (rw),
		.lds       (lds),
		.addr      (addr),
		.din       (din),
		.fdc       (fdc),
		.acsi_busy (acsi.busy),
		.ack_pulse (ack_pulse),
		.strobe    (strobe),
		.base      (base),
		.scnt      (scnt),
		.dout      (dout)
	);

	fdc_emul #(
		.MOTOR_CYCLES (MOTOR_CYCLES)
	) u_fdc (
		.clk       (clk),
		.reset     (reset),
		.strobe    (strobe),
		.wr_prot   (fdc_wr_prot),
		.ack_pulse (ack_pulse),
		.regs      (fdc),
		.xfer_req  (fdc_req),
		.irq       (fdc_irq)
	);

	acsi_cmd u_acsi (
		.clk       (clk),
		.reset     (reset),
		.strobe    (strobe),
		.enable    (acsi_enable),
		.ack_pulse (ack_pulse),
		.stat      (acsi),
		.xfer_req  (acsi_req),
		.irq       (acsi_irq)
	);

	dio_link u_dio (
		.clk       (clk),
		.reset     (reset),
		.ack       (dio_ack),
		.nak       (dio_nak),
		.fdc_req   (fdc_req),
		.acsi_req  (acsi_req),
		.dio_idx   (dio_idx),
		.fdc       (fdc),
		.acsi      (acsi),
		.base      (base),
		.scnt      (scnt),
		.drv_sel   (drv_sel),
		.drv_side  (drv_side),
		.ack_pulse (ack_pulse),
		.br        (br),
		.dio_data  (dio_data)
	);

endmodule

`default_nettype wire

// File: dv/dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_tb
	import st_bus_pkg::*;
();

	// kinds of table steps
	typedef enum logic [3:0] {
		op_wr,
		op_rd,
		op_dio,
		op_ack,
		op_nak,
		op_irq,
		op_br_fall,
		op_lvl,
		op_cfg
	} op_e;

	typedef struct packed {
		op_e         op;
		reg_addr_e   addr;
		logic [15:0] mode_word;
		logic [15:0] data;
		logic [15:0] exp;
		logic [15:0] mask;
	} step_t;

	localparam int          wait_limit   = 64;
	localparam logic [1:0]  drv_sel_val  = 2'b10;
	localparam logic        drv_side_val = 1'b1;
	// mode words in front of data register accesses
	localparam logic [15:0] m_cmd        = 16'h0000;
	localparam logic [15:0] m_track      = 16'h0002;
	localparam logic [15:0] m_sector     = 16'h0004;
	localparam logic [15:0] m_data       = 16'h0006;
	localparam logic [15:0] m_acsi       = 16'h0008;
	localparam logic [15:0] m_acsi_next  = 16'h000a;
	localparam logic [15:0] m_scnt       = 16'h0010;
	localparam logic [15:0] all          = 16'hffff;
	// motor bit depends on elapsed cycles
	localparam logic [15:0] no_motor     = 16'hff7f;

	logic        clk;
	logic        reset;
	logic        sel;
	logic        rw;
	logic        lds;
	reg_addr_e   addr;
	logic [15:0] din;
	logic [15:0] dout;
	logic        irq;
	logic        br;
	logic        fdc_wr_prot;
	logic [7:0]  acsi_enable;
	logic [4:0]  dio_idx;
	logic [7:0]  dio_data;
	logic        dio_ack;
	logic        dio_nak;
	logic        drv_side;
	logic [1:0]  drv_sel;

	step_t       steps[$];
	string       names[$];
	logic [31:0] seed;
	bit          step_ok;
	int          n_pass;
	int          n_fail;
	int          i;

	dma_top #(
		.MOTOR_CYCLES (20)
	) uut (
		.clk         (clk),
		.reset       (reset),
		.sel         (sel),
		.rw          (rw),
		.lds         (lds),
		.addr        (addr),
		.din         (din),
		.dout        (dout),
		.irq         (irq),
		.br          (br),
		.fdc_wr_prot (fdc_wr_prot),
		.acsi_enable (acsi_enable),
		.dio_idx     (dio_idx),
		.dio_data    (dio_data),
		.dio_ack     (dio_ack),
		.dio_nak     (dio_nak),
		.drv_side    (drv_side),
		.drv_sel     (drv_sel)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// lcg, upper middle byte has the best spread
	function automatic logic [7:0] rand_byte();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	task automatic add_step(input string name, input op_e op, input reg_addr_e a,
		input logic [15:0] mode_word, input logic [15:0] data,
		input logic [15:0] exp, input logic [15:0] mask);
		step_t s;
		s.op        = op;
		s.addr      = a;
		s.mode_word = mode_word;
		s.data      = data;
		s.exp       = exp;
		s.mask      = mask;
		steps.push_back(s);
		names.push_back(name);
	endtask

	task automatic add_wr(input string name, input reg_addr_e a, input logic [15:0] m,
		input logic [15:0] d);
		add_step(name, op_wr, a, m, d, 16'h0000, 16'h0000);
	endtask

	task automatic add_rd(input string name, input reg_addr_e a, input logic [15:0] m,
		input logic [15:0] e, input logic [15:0] mask);
		add_step(name, op_rd, a, m, 16'h0000, e, mask);
	endtask

	task automatic add_dio(input string name, input logic [4:0] idx, input logic [7:0] e);
		add_step(name, op_dio, ctrl_data, m_cmd, {11'd0, idx}, {8'h00, e}, all);
	endtask

	task automatic add_op(input string name, input op_e op);
		add_step(name, op, ctrl_data, m_cmd, 16'h0000, 16'h0000, 16'h0000);
	endtask

	// expected {irq, br}
	task automatic add_lvl(input string name, input logic [1:0] e);
		add_step(name, op_lvl, ctrl_data, m_cmd, 16'h0000, {14'd0, e}, all);
	endtask

	task automatic add_cfg(input string name, input logic [7:0] en, input logic wp);
		add_step(name, op_cfg, ctrl_data, m_cmd, {en, 7'd0, wp}, 16'h0000, 16'h0000);
	endtask

	// command, irq, status with track 0 flag, irq clear, track readback
	task automatic add_type1(input string name, input logic [7:0] cmd, input logic [7:0] trk);
		add_wr({name, " cmd"}, ctrl_data, m_cmd, {8'h00, cmd});
		add_op({name, " irq"}, op_irq);
		add_rd({name, " status"}, ctrl_data, m_cmd, {13'd0, trk == 8'd0, 2'b00}, no_motor);
		add_lvl({name, " irq clear"}, 2'b00);
		add_rd({name, " track"}, ctrl_data, m_track, {8'h00, trk}, all);
	endtask

	task automatic build_table();
		logic [7:0] b_hi;
		logic [7:0] b_mid;
		logic [7:0] b_lo;
		logic [7:0] sc;
		logic [7:0] dat;
		logic [7:0] trk;
		logic [7:0] sect;
		logic [7:0] first;
		logic [7:0] en;
		logic [7:0] parm [5];
		logic [7:0] snap [9];
		logic       dir;
		int         k;
		b_hi  = rand_byte();
		b_mid = rand_byte();
		b_lo  = rand_byte();
		// nonzero so the dma status shows pending sectors
		sc    = rand_byte() | 8'h01;
		add_wr("base hi", base_hi, m_cmd, {8'h00, b_hi});
		add_wr("base mid", base_mid, m_cmd, {8'h00, b_mid});
		add_wr("base lo", base_lo, m_cmd, {8'h00, b_lo});
		add_wr("scnt write", ctrl_data, m_scnt, {8'h00, sc});
		add_rd("base hi read", base_hi, m_cmd, {8'h00, b_hi}, all);
		add_rd("base mid read", base_mid, m_cmd, {8'h00, b_mid}, all);
		add_rd("base lo read", base_lo, m_cmd, {8'h00, b_lo}, all);
		add_rd("scnt read", ctrl_data, m_scnt, {8'h00, sc}, all);
		add_rd("dma status pending", mode, m_cmd, 16'h0003, all);
		add_wr("scnt zero", ctrl_data, m_scnt, 16'h0000);
		add_rd("dma status empty", mode, m_cmd, 16'h0001, all);
		add_wr("scnt reload", ctrl_data, m_scnt, {8'h00, sc});
		// type i commands, track model kept here
		dat = rand_byte();
		trk = rand_byte();
		add_wr("track preset", ctrl_data, m_track, {8'h00, trk});
		add_wr("data reg", ctrl_data, m_data, {8'h00, dat});
		trk = 8'h00;
		add_type1("restore", 8'h00, trk);
		trk = dat;
		add_type1("seek", 8'h10, trk);
		dir = 1'b1;
		trk = trk + 8'd1;
		add_type1("step in", 8'h50, trk);
		trk = dir ? trk + 8'd1 : trk - 8'd1;
		add_type1("step again in", 8'h30, trk);
		dir = 1'b0;
		trk = trk - 8'd1;
		add_type1("step out", 8'h70, trk);
		trk = dir ? trk + 8'd1 : trk - 8'd1;
		add_type1("step again out", 8'h30, trk);
		// read sector and snapshot
		sect = rand_byte();
		add_wr("sector reg", ctrl_data, m_sector, {8'h00, sect});
		add_wr("read sector cmd", ctrl_data, m_cmd, 16'h0080);
		add_lvl("read sector br", 2'b01);
		snap[0] = b_hi;
		snap[1] = b_mid;
		snap[2] = b_lo;
		snap[3] = sc;
		snap[4] = 8'h80;
		snap[5] = trk;
		snap[6] = sect;
		snap[7] = dat;
		// acsi idle, fdc still waiting
		snap[8] = {3'b000, 1'b0, drv_sel_val, drv_side_val, 1'b1};
		for (k = 0; k < 9; k++)
			add_dio($sformatf("dio index %0d", k), 5'(k), snap[k]);
		add_op("sector ack", op_ack);
		add_op("sector br release", op_br_fall);
		add_op("sector irq", op_irq);
		add_dio("dio scnt cleared", 5'd3, 8'h00);
		add_rd("dma status done", mode, m_cmd, 16'h0001, all);
		add_rd("sector status", ctrl_data, m_cmd, 16'h0000, no_motor);
		add_lvl("sector irq clear", 2'b00);
		// write protected disk
		add_cfg("write protect on", 8'h00, 1'b1);
		add_wr("write sector cmd", ctrl_data, m_cmd, 16'h00a0);
		add_lvl("write sector no br", 2'b00);
		add_op("write sector irq", op_irq);
		add_rd("write sector status", ctrl_data, m_cmd, 16'h00c0, all);
		// acsi command block, only this target enabled
		first = rand_byte();
		en    = 8'h01 << first[7:5];
		add_cfg("acsi target enable", en, 1'b0);
		add_wr("acsi first byte", ctrl_data, m_acsi, {8'h00, first});
		add_op("acsi first irq", op_irq);
		add_rd("acsi first status", ctrl_data, m_acsi, 16'h0000, all);
		add_lvl("acsi first irq clear", 2'b00);
		for (k = 0; k < 5; k++) begin
			parm[k] = rand_byte();
			add_wr($sformatf("acsi byte %0d", k + 1), ctrl_data, m_acsi_next,
				{8'h00, parm[k]});
			if (k < 4) begin
				add_op($sformatf("acsi byte %0d irq", k + 1), op_irq);
				add_rd($sformatf("acsi byte %0d status", k + 1), ctrl_data, m_acsi,
					16'h0000, all);
				add_lvl($sformatf("acsi byte %0d irq clear", k + 1), 2'b00);
			end
		end
		add_lvl("acsi br", 2'b01);
		add_rd("acsi busy status", ctrl_data, m_acsi, 16'h0008, all);
		add_dio("dio acsi command", 5'd9, first);
		for (k = 0; k < 5; k++)
			add_dio($sformatf("dio acsi byte %0d", k + 1), 5'(10 + k), parm[k]);
		add_op("acsi ack", op_ack);
		add_op("acsi br release", op_br_fall);
		add_op("acsi done irq", op_irq);
		add_rd("acsi idle status", ctrl_data, m_acsi, 16'h0000, all);
		add_lvl("acsi irq clear", 2'b00);
		// neighbour target, not enabled
		add_wr("disabled target byte", ctrl_data, m_acsi, {8'h00, first ^ 8'h20});
		add_lvl("disabled target no irq", 2'b00);
		add_wr("read sector for nak", ctrl_data, m_cmd, 16'h0080);
		add_lvl("nak br", 2'b01);
		add_op("nak", op_nak);
		add_op("nak br release", op_br_fall);
		add_lvl("nak no irq", 2'b00);
	endtask

	task automatic cpu_write(input reg_addr_e a, input logic [15:0] d);
		@(posedge clk);
		sel  <= 1'b1;
		rw   <= 1'b0;
		lds  <= 1'b0;
		addr <= a;
		din  <= d;
		@(posedge clk);
		sel <= 1'b0;
		rw  <= 1'b1;
		lds <= 1'b1;
	endtask

	// dout sampled mid cycle, strobe edge ends the access
	task automatic cpu_read(input reg_addr_e a, output logic [15:0] d);
		@(posedge clk);
		sel  <= 1'b1;
		rw   <= 1'b1;
		lds  <= 1'b0;
		addr <= a;
		@(negedge clk);
		d = dout;
		@(posedge clk);
		sel <= 1'b0;
		lds <= 1'b1;
	endtask

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] got, input logic [15:0] mask);
		assert ((got & mask) == (exp & mask)) else begin
			$display("ERR %s: expected %h, actual %h", name, exp & mask, got & mask);
			step_ok = 1'b0;
		end
	endtask

	task automatic wait_for(input string name, input bit on_br, input logic level);
		int   n;
		logic seen;
		n = 0;
		do begin
			@(negedge clk);
			seen = on_br ? br : irq;
			n++;
		end while (seen !== level && n < wait_limit);
		assert (seen === level) else begin
			$display("%s: %s did not reach %0d within %0d cycles", name,
				on_br ? "br" : "irq", level, wait_limit);
			step_ok = 1'b0;
		end
	endtask

	// level held two cycles, long enough for the synchronizer
	task automatic pulse_link(input bit use_ack);
		@(posedge clk);
		if (use_ack)
			dio_ack <= 1'b1;
		else
			dio_nak <= 1'b1;
		repeat (2) @(posedge clk);
		dio_ack <= 1'b0;
		dio_nak <= 1'b0;
	endtask

	task automatic run_step(input int idx);
		step_t       s;
		logic [15:0] got;
		s = steps[idx];
		step_ok = 1'b1;
		// data register picks its target through the mode register
		if ((s.op == op_wr || s.op == op_rd) && s.addr == ctrl_data)
			cpu_write(mode, s.mode_word);
		case (s.op)
			op_wr: cpu_write(s.addr, s.data);
			op_rd: begin
				cpu_read(s.addr, got);
				check_value(names[idx], s.exp, got, s.mask);
			end
			op_dio: begin
				@(posedge clk);
				dio_idx <= s.data[4:0];
				@(negedge clk);
				check_value(names[idx], s.exp, {8'h00, dio_data}, s.mask);
			end
			op_ack: pulse_link(1'b1);
			op_nak: pulse_link(1'b0);
			op_irq: wait_for(names[idx], 1'b0, 1'b1);
			op_br_fall: wait_for(names[idx], 1'b1, 1'b0);
			op_lvl: begin
				@(negedge clk);
				check_value(names[idx], s.exp, {14'd0, irq, br}, s.mask);
			end
			op_cfg: begin
				@(posedge clk);
				fdc_wr_prot <= s.data[0];
				acsi_enable <= s.data[15:8];
			end
			default: begin
				$display("%s: unknown step kind", names[idx]);
				step_ok = 1'b0;
			end
		endcase
		if (step_ok) begin
			$display("ok   %s", names[idx]);
			n_pass++;
		end else
			n_fail++;
	endtask

	initial begin
		reset       = 1'b1;
		sel         = 1'b0;
		rw          = 1'b1;
		lds         = 1'b1;
		addr        = ctrl_data;
		din         = 16'h0000;
		fdc_wr_prot = 1'b0;
		acsi_enable = 8'h00;
		dio_idx     = 5'd0;
		dio_ack     = 1'b0;
		dio_nak     = 1'b0;
		drv_side    = drv_side_val;
		drv_sel     = drv_sel_val;
		seed        = 32'd30544;
		n_pass      = 0;
		n_fail      = 0;
		build_table();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < steps.size(); i++)
			run_step(i);
		$display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/st_bus_pkg.sv
hw/disk_ctrl_pkg.sv
hw/dma_regfile.sv
hw/fdc_emul.sv
hw/acsi_cmd.sv
hw/dio_link.sv
hw/dma_top.sv
dv/dma_tb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdma_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module dma_tb -o Vdma_tb

run: obj_dir/Vdma_tb
	./obj_dir/Vdma_tb > sim.log; cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
